// File: test/uart_command_tb.sv
`timescale 1ns/1ps

module uart_command_tb;

    // One table row: a frame sent to the DUT and what comes back
    typedef struct packed {
        logic [127:0]    name;
        logic [1:0]      nbytes;
        logic [2:0][7:0] bytes;
        logic            expect_resp;
    } frame_t;

    logic clk;
    logic reset;
    logic rx;
    logic tx;

    frame_t     frames [8];
    logic [7:0] model_regs [16];
    logic [31:0] rng;
    logic [7:0] addr_a;
    logic [7:0] addr_b;
    logic [7:0] data_a;
    logic [7:0] data_b;
    logic [7:0] expected;
    logic [7:0] got;
    logic       found;
    int         errors;

    uart_command_top uart_command_top_inst (
        .clk   (clk),
        .reset (reset),
        .rx    (rx),
        .tx    (tx)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic frame_t make_frame(input logic [127:0] name, input logic [1:0] nbytes,
                                          input logic [7:0] b0, input logic [7:0] b1,
                                          input logic [7:0] b2, input logic expect_resp);
        frame_t f;
        f.name        = name;
        f.nbytes      = nbytes;
        f.bytes[0]    = b0;
        f.bytes[1]    = b1;
        f.bytes[2]    = b2;
        f.expect_resp = expect_resp;
        return f;
    endfunction

    // Reference model of the register file and its answers
    task automatic predict(input frame_t f, output logic [7:0] resp);
        logic [3:0] a;
        a = f.bytes[1][3:0];
        case (f.bytes[0])
            uart_pkg::op_write: begin
                model_regs[a] = f.bytes[2];
                resp = uart_pkg::resp_ack;
            end
            uart_pkg::op_read: begin
                resp = model_regs[a];
            end
            uart_pkg::op_add: begin
                model_regs[a] = model_regs[a] + f.bytes[2];
                resp = model_regs[a];
            end
            default: begin
                resp = uart_pkg::resp_error;
            end
        endcase
    endtask

    // Start bit, eight data bits LSB first, then the given stop bit
    task automatic send_byte(input logic [7:0] data, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data, 1'b0};
        for (int b = 0; b < 10; b++) begin
            @(posedge clk);
            rx <= bits[b];
            repeat (uart_pkg::clocks_per_bit - 1) @(posedge clk);
        end
    endtask

    task automatic send_frame(input frame_t f);
        for (int i = 0; i < f.nbytes; i++) begin
            send_byte(f.bytes[i], 1'b1);
        end
    endtask

    task automatic receive_byte(input logic [127:0] name, output logic [7:0] data,
                                output logic arrived);
        int   waited;
        logic prev;
        data    = 8'h00;
        arrived = 1'b0;
        waited  = 0;
        prev    = 1'b1;
        while (!arrived && waited < 60 * uart_pkg::clocks_per_bit) begin
            @(posedge clk);
            if (prev && !tx) begin
                arrived = 1'b1;
            end
            prev   = tx;
            waited = waited + 1;
        end
        if (arrived) begin
            // Move to the centre of the start bit
            repeat (uart_pkg::clocks_per_bit / 2 - 1) @(posedge clk);
            assert (tx === 1'b0) else begin
                $display("%s: start bit of the response did not stay low", name);
                errors++;
            end
            for (int b = 0; b < 8; b++) begin
                repeat (uart_pkg::clocks_per_bit) @(posedge clk);
                data[b] = tx;
            end
            repeat (uart_pkg::clocks_per_bit) @(posedge clk);
            assert (tx === 1'b1) else begin
                $display("%s: stop bit of the response byte is low", name);
                errors++;
            end
        end
    endtask

    // Line must stay high for the given number of cycles
    task automatic check_line_idle(input logic [127:0] name, input int cycles);
        logic quiet;
        quiet = 1'b1;
        repeat (cycles) begin
            @(posedge clk);
            if (tx !== 1'b1) begin
                quiet = 1'b0;
            end
        end
        assert (quiet) else begin
            $display("%s: tx left the idle level while no response was due", name);
            errors++;
        end
    endtask

    initial begin
        clk    = 1'b0;
        reset  = 1'b1;
        rx     = 1'b1;
        errors = 0;
        rng    = 32'd52;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = 8'h00;
        end

        rng    = xorshift(rng);
        addr_a = rng[7:0];
        rng    = xorshift(rng);
        // Upper nibble is random too; only the low four bits select a register
        addr_b = {rng[7:4], addr_a[3:0] ^ 4'h5};
        rng    = xorshift(rng);
        // Top bit set so adding 8'h90 always carries past 255
        data_a = rng[7:0] | 8'h80;
        rng    = xorshift(rng);
        data_b = rng[7:0];

        // Unknown opcode, which would draw an answer at once if the byte got through
        frames[0] = make_frame("bad_stop", 2'd1, 8'h58, 8'h00, 8'h00, 1'b0);
        frames[1] = make_frame("write_rand", 2'd3, uart_pkg::op_write, addr_a, data_a, 1'b1);
        frames[2] = make_frame("read_back", 2'd2, uart_pkg::op_read, addr_a, 8'h00, 1'b1);
        frames[3] = make_frame("add_wrap", 2'd3, uart_pkg::op_add, addr_a, 8'h90, 1'b1);
        frames[4] = make_frame("read_sum", 2'd2, uart_pkg::op_read, addr_a, 8'h00, 1'b1);
        frames[5] = make_frame("bad_opcode", 2'd1, 8'h58, 8'h00, 8'h00, 1'b1);
        frames[6] = make_frame("read_blank", 2'd2, uart_pkg::op_read, addr_b, 8'h00, 1'b1);
        frames[7] = make_frame("add_blank", 2'd3, uart_pkg::op_add, addr_b, data_b, 1'b1);

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        check_line_idle("idle_after_reset", 10 * uart_pkg::clocks_per_bit);

        for (int i = 0; i < 8; i++) begin
            if (!frames[i].expect_resp) begin
                // Silent rows go out with a low stop bit
                send_byte(frames[i].bytes[0], 1'b0);
                @(posedge clk);
                rx <= 1'b1;
                check_line_idle(frames[i].name, 20 * uart_pkg::clocks_per_bit);
            end else begin
                predict(frames[i], expected);
                // Response starts before the last stop bit ends, so listen while sending
                fork
                    send_frame(frames[i]);
                    receive_byte(frames[i].name, got, found);
                join
                assert (found) else begin
                    $display("%s: no response byte arrived", frames[i].name);
                    errors++;
                end
                if (found) begin
                    assert (got === expected) else begin
                        $display("ERROR %s: expected %02h, actual %02h",
                                 frames[i].name, expected, got);
                        errors++;
                    end
                end
            end
        end

        repeat (2 * uart_pkg::clocks_per_bit) @(posedge clk);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
verilog/uart_pkg.sv
verilog/uart_receiver.sv
verilog/uart_transmitter.sv
verilog/command_decoder.sv
verilog/register_executor.sv
verilog/response_builder.sv
verilog/uart_command_top.sv
test/uart_command_tb.sv

// File: verilog/command_decoder.sv
`timescale 1ns/1ps

module command_decoder (
    input  logic               clk,
    input  logic               reset,
    input  logic [7:0]         rx_byte,
    input  logic               rx_strobe,
    output uart_pkg::command_t cmd,
    output logic               cmd_strobe
);
    typedef enum logic [1:0] {
        wait_op,
        wait_addr,
        wait_data
    } dec_state_t;

    dec_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= wait_op;
            cmd        <= '0;
            cmd_strobe <= 1'b0;
        end else begin
            cmd_strobe <= 1'b0;
            if (rx_strobe) begin
                case (state)
                    wait_op: begin
                        case (rx_byte)
                            uart_pkg::op_write: begin
                                cmd.kind <= uart_pkg::cmd_write;
                                state    <= wait_addr;
                            end
                            uart_pkg::op_read: begin
                                cmd.kind <= uart_pkg::cmd_read;
                                state    <= wait_addr;
                            end
                            uart_pkg::op_add: begin
                                cmd.kind <= uart_pkg::cmd_add;
                                state    <= wait_addr;
                            end
                            default: begin
                                // Unknown opcode is reported right away
                                cmd.kind   <= uart_pkg::cmd_bad;
                                cmd_strobe <= 1'b1;
                            end
                        endcase
                    end
                    wait_addr: begin
                        cmd.addr <= rx_byte[3:0];
                        if (cmd.kind == uart_pkg::cmd_read) begin
                            cmd_strobe <= 1'b1;
                            state      <= wait_op;
                        end else begin
                            state <= wait_data;
                        end
                    end
                    default: begin
                        cmd.data   <= rx_byte;
                        cmd_strobe <= 1'b1;
                        state      <= wait_op;
                    end
                endcase
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) cmd_strobe |=> !cmd_strobe);

endmodule

// File: verilog/register_executor.sv
`timescale 1ns/1ps

module register_executor (
    input  logic               clk,
    input  logic               reset,
    input  uart_pkg::command_t cmd,
    input  logic               cmd_strobe,
    output uart_pkg::result_t  result,
    output logic               result_strobe
);
    logic [7:0] regs [16];
    logic [7:0] current;
    logic [7:0] new_value;

    assign current = regs[cmd.addr];

    // Value the addressed register holds once the command is done
    always_comb begin
        case (cmd.kind)
            uart_pkg::cmd_write: new_value = cmd.data;
            uart_pkg::cmd_add:   new_value = current + cmd.data;
            uart_pkg::cmd_read:  new_value = current;
            default:             new_value = 8'h00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (cmd_strobe) begin
            if (cmd.kind == uart_pkg::cmd_write || cmd.kind == uart_pkg::cmd_add) begin
                regs[cmd.addr] <= new_value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_strobe <= 1'b0;
        end else begin
            result_strobe <= cmd_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
        end else if (cmd_strobe) begin
            result.kind  <= cmd.kind;
            result.value <= new_value;
        end
    end

endmodule

// File: verilog/response_builder.sv
`timescale 1ns/1ps

module response_builder (
    input  logic              clk,
    input  logic              reset,
    input  uart_pkg::result_t result,
    input  logic              result_strobe,
    input  logic              tx_ready,
    output logic [7:0]        tx_byte,
    output logic              tx_valid
);
    logic [7:0] resp_byte;
    logic       load;

    always_comb begin
        case (result.kind)
            uart_pkg::cmd_write: resp_byte = uart_pkg::resp_ack;
            uart_pkg::cmd_bad:   resp_byte = uart_pkg::resp_error;
            default:             resp_byte = result.value;
        endcase
    end

    // A held byte that is not leaving this cycle wins over a new result
    assign load = result_strobe && (!tx_valid || tx_ready);

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_valid <= 1'b0;
        end else if (load) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_byte <= 8'h00;
        end else if (load) begin
            tx_byte <= resp_byte;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte));

    // Host must wait for each response, so the buffer is never full here
    assert property (@(posedge clk) disable iff (reset)
        result_strobe |-> !tx_valid || tx_ready);

endmodule

// File: verilog/uart_command_top.sv
`timescale 1ns/1ps

module uart_command_top (
    input  logic clk,
    input  logic reset,
    input  logic rx,
    output logic tx
);
    logic [7:0]         rx_byte;
    logic               rx_strobe;
    uart_pkg::command_t cmd;
    logic               cmd_strobe;
    uart_pkg::result_t  result;
    logic               result_strobe;
    logic [7:0]         tx_byte;
    logic               tx_valid;
    logic               tx_ready;

    uart_receiver uart_receiver_inst (
        .clk       (clk),
        .reset     (reset),
        .rx        (rx),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe)
    );

    command_decoder command_decoder_inst (
        .clk        (clk),
        .reset      (reset),
        .rx_byte    (rx_byte),
        .rx_strobe  (rx_strobe),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe)
    );

    register_executor register_executor_inst (
        .clk           (clk),
        .reset         (reset),
        .cmd           (cmd),
        .cmd_strobe    (cmd_strobe),
        .result        (result),
        .result_strobe (result_strobe)
    );

    response_builder response_builder_inst (
        .clk           (clk),
        .reset         (reset),
        .result        (result),
        .result_strobe (result_strobe),
        .tx_ready      (tx_ready),
        .tx_byte       (tx_byte),
        .tx_valid      (tx_valid)
    );

    uart_transmitter uart_transmitter_inst (
        .clk      (clk),
        .reset    (reset),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx       (tx)
    );

endmodule

// File: verilog/uart_pkg.sv
package uart_pkg;

    // Clock cycles per serial bit, shared by both UART ends
    localparam int clocks_per_bit = 16;

    // ASCII opcode bytes
    localparam logic [7:0] op_write = 8'h57;
    localparam logic [7:0] op_read  = 8'h52;
    localparam logic [7:0] op_add   = 8'h41;

    // ASCII response bytes for write acknowledge and unknown opcode
    localparam logic [7:0] resp_ack   = 8'h4b;
    localparam logic [7:0] resp_error = 8'h3f;

    typedef enum logic [1:0] {
        cmd_write,
        cmd_read,
        cmd_add,
        cmd_bad
    } cmd_kind_t;

    // Decoded frame, 14 bits
    typedef struct packed {
        cmd_kind_t  kind;
        logic [3:0] addr;
        logic [7:0] data;
    } command_t;

    // Executed command, value is the register contents afterwards
    typedef struct packed {
        cmd_kind_t  kind;
        logic [7:0] value;
    } result_t;

endpackage

// File: verilog/uart_receiver.sv
`timescale 1ns/1ps

module uart_receiver (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_strobe
);
    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t  state;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    logic [7:0] data_shift;
    logic [3:0] bit_counter;
    logic [$clog2(uart_pkg::clocks_per_bit)-1:0] clock_counter;
    logic       falling_edge;
    logic       half_bit;
    logic       full_bit;

    assign falling_edge = rx_prev && !rx_sync;
    assign half_bit     = clock_counter == uart_pkg::clocks_per_bit / 2 - 1;
    assign full_bit     = clock_counter == uart_pkg::clocks_per_bit - 1;
    assign rx_byte      = data_shift;

    // Two-flop synchronizer plus one more stage for edge detection
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= rx_idle;
            clock_counter <= '0;
            bit_counter   <= 4'd0;
            rx_strobe     <= 1'b0;
        end else begin
            rx_strobe     <= 1'b0;
            clock_counter <= clock_counter + 1'b1;
            case (state)
                rx_idle: begin
                    clock_counter <= '0;
                    if (falling_edge) begin
                        state <= rx_start;
                    end
                end
                rx_start: begin
                    // Line must still be low half a bit later, else it was a glitch
                    if (half_bit) begin
                        clock_counter <= '0;
                        bit_counter   <= 4'd0;
                        state         <= rx_sync ? rx_idle : rx_data;
                    end
                end
                rx_data: begin
                    if (full_bit) begin
                        clock_counter <= '0;
                        bit_counter   <= bit_counter + 1'b1;
                        if (bit_counter == 4'd7) begin
                            state <= rx_stop;
                        end
                    end
                end
                default: begin
                    // Centre of the stop bit; a low stop bit drops the byte
                    if (full_bit) begin
                        rx_strobe <= rx_sync;
                        state     <= rx_idle;
                    end
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (reset) begin
            data_shift <= 8'h00;
        end else if (state == rx_data && full_bit) begin
            data_shift <= {rx_sync, data_shift[7:1]};
        end
    end

    assert property (@(posedge clk) disable iff (reset) rx_strobe |=> !rx_strobe);

endmodule

// File: verilog/uart_transmitter.sv
`timescale 1ns/1ps

module uart_transmitter (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_byte,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       tx
);
    logic [9:0] tx_shift;
    logic [3:0] bit_counter;
    logic [$clog2(uart_pkg::clocks_per_bit)-1:0] clock_counter;
    logic       tx_running;
    logic       symbol_edge;
    logic       start;

    // Bit counter is 1 for the start bit through 10 for the stop bit
    assign tx_running  = bit_counter != 4'd0;
    assign tx_ready    = !tx_running;
    assign start       = tx_valid && tx_ready;
    assign symbol_edge = clock_counter == uart_pkg::clocks_per_bit - 1;
    assign tx          = tx_shift[0];

    // Cycles within the current bit, parked at zero while idle
    always_ff @(posedge clk) begin
        if (reset || symbol_edge || !tx_running) begin
            clock_counter <= '0;
        end else begin
            clock_counter <= clock_counter + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_counter <= 4'd0;
        end else if (start) begin
            bit_counter <= 4'd1;
        end else if (symbol_edge && tx_running) begin
            if (bit_counter == 4'd10) begin
                bit_counter <= 4'd0;
            end else begin
                bit_counter <= bit_counter + 1'b1;
            end
        end
    end

    // Ones shift in behind the frame so the line rests high afterwards
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_shift <= '1;
        end else if (start) begin
            tx_shift <= {1'b1, tx_byte, 1'b0};
        end else if (symbol_edge && tx_running) begin
            tx_shift <= {1'b1, tx_shift[9:1]};
        end
    end

    assert property (@(posedge clk) disable iff (reset) tx_ready |-> tx);

endmodule
